/* compile.f */
logic/credit_pkg.sv
logic/grant_decoder.sv
logic/ovc_credit_slot.sv
logic/full_mask_gen.sv
logic/credit_counter_top.sv
bench/credit_counter_sva.sv
bench/credit_counter_tb.sv

/* bench/credit_counter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_counter_tb;
    import credit_pkg::*;

    localparam int NUM_STEPS      = 17;
    localparam int MAX_IDLE       = 3;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_STEPS * (MAX_IDLE + 2) + RESET_CYCLES + 20;

    // vectors of the scenario around ovc 9 (port 2 local vc 1)
    localparam ovc_vec_t       NONE  = '0;
    localparam ovc_vec_t       ALL   = '1;
    localparam ovc_vec_t       OVC9  = 20'h00200;
    localparam ovc_vec_t       IVC1  = 20'h00002;   // port 0 vc 1 holding ovc 9
    localparam ovc_vec_t       IVC17 = 20'h20000;   // port 4 vc 1 holding ovc 9
    localparam ovc_vec_t       IVC18 = 20'h40000;   // port 4 vc 2 holding ovc 1
    localparam port_dest_all_t GDP_P0_TO_P2 = 20'h00002;  // dest index 1 at port 0
    localparam port_dest_all_t GDP_P4_TO_P2 = 20'h40000;  // dest index 2 at port 4

    logic           clk = 1'b0;
    logic           reset;
    ovc_vec_t       ovc_allocated;
    ovc_vec_t       flit_is_tail;
    ovc_num_all_t   assigned_ovc_num;
    dest_all_t      dest_port;
    port_dest_all_t granted_dest_port;
    ovc_vec_t       granted_ivc;
    ovc_vec_t       credit_in;
    ovc_vec_t       ivc_sw_grant;
    ovc_vec_t       ovc_available;
    ovc_vec_t       assigned_ovc_not_full;

    // stimulus table
    string          tab_name [NUM_STEPS];
    ovc_vec_t       tab_alloc [NUM_STEPS];
    ovc_vec_t       tab_tail [NUM_STEPS];
    ovc_vec_t       tab_gnt_ivc [NUM_STEPS];
    port_dest_all_t tab_gnt_dest [NUM_STEPS];
    ovc_vec_t       tab_credit [NUM_STEPS];
    ovc_vec_t       tab_sw [NUM_STEPS];
    int             tab_idle [NUM_STEPS];
    ovc_vec_t       tab_exp_avail [NUM_STEPS];
    ovc_vec_t       tab_exp_not_full [NUM_STEPS];
    int             num_filled = 0;

    // reference model state
    int             ref_count [NUM_OVC];
    logic           ref_status [NUM_OVC];
    ovc_vec_t       model_avail;
    ovc_vec_t       model_not_full;

    int             cycle_count = 0;

    credit_counter_top credit_counter_top_inst (
        .clk                   (clk),
        .reset                 (reset),
        .ovc_allocated         (ovc_allocated),
        .flit_is_tail          (flit_is_tail),
        .assigned_ovc_num      (assigned_ovc_num),
        .dest_port             (dest_port),
        .granted_dest_port     (granted_dest_port),
        .granted_ivc           (granted_ivc),
        .credit_in             (credit_in),
        .ivc_sw_grant          (ivc_sw_grant),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic stop_on_failure(input string msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("timeout: run did not finish within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    // output port named by destination index j at input port p
    function automatic int route_port(input int p, input int j);
        if (j < p) begin
            return j;
        end
        return j + 1;
    endfunction

    task automatic add_step(
        input string          name,
        input ovc_vec_t       alloc,
        input ovc_vec_t       tail,
        input ovc_vec_t       gnt_ivc,
        input port_dest_all_t gnt_dest,
        input ovc_vec_t       credit,
        input ovc_vec_t       sw,
        input int             idle,
        input ovc_vec_t       exp_avail,
        input ovc_vec_t       exp_not_full
    );
        tab_name[num_filled]         = name;
        tab_alloc[num_filled]        = alloc;
        tab_tail[num_filled]         = tail;
        tab_gnt_ivc[num_filled]      = gnt_ivc;
        tab_gnt_dest[num_filled]     = gnt_dest;
        tab_credit[num_filled]       = credit;
        tab_sw[num_filled]           = sw;
        tab_idle[num_filled]         = idle;
        tab_exp_avail[num_filled]    = exp_avail;
        tab_exp_not_full[num_filled] = exp_not_full;
        num_filled++;
    endtask

    task automatic build_table();
        add_step("after_reset", NONE, NONE, NONE, '0, NONE, NONE, 3, ALL, ALL);
        add_step("alloc_ovc9", OVC9, NONE, NONE, '0, NONE, NONE, 3, ~OVC9, ALL);
        // tail leaves while a credit comes back so the count holds at 2
        add_step("tail_p0_release", NONE, IVC1, IVC1, GDP_P0_TO_P2, OVC9, NONE, 3, ALL, ALL);
        add_step("credit_refill", NONE, NONE, NONE, '0, OVC9, NONE, 3, ALL, ALL);
        add_step("realloc_ovc9", OVC9, NONE, NONE, '0, NONE, NONE, 3, ~OVC9, ALL);
        add_step("body_p0", NONE, NONE, IVC1, GDP_P0_TO_P2, NONE, NONE, 3, ~OVC9, ALL);
        add_step("body_p4_full", NONE, NONE, IVC17, GDP_P4_TO_P2, NONE, NONE, 3,
                 ~OVC9, ~(IVC1 | IVC17));
        add_step("credit_to_1", NONE, NONE, NONE, '0, OVC9, NONE, 3, ~OVC9, ALL);
        add_step("tail_p4_release", NONE, IVC17, IVC17, GDP_P4_TO_P2, OVC9, NONE, 3,
                 ~OVC9, ALL);
        add_step("sw_grant_p0", NONE, NONE, NONE, '0, NONE, IVC1, 3, ~OVC9, ~IVC1);
        add_step("sw_grant_p4", NONE, NONE, NONE, '0, NONE, IVC17, 3, ~OVC9, ~IVC17);
        add_step("sw_grant_other_ovc", NONE, NONE, NONE, '0, NONE, IVC1 | IVC18, 3,
                 ~OVC9, ~IVC1);
        add_step("credit_to_2_free", NONE, NONE, NONE, '0, OVC9, NONE, 3, ALL, ALL);
        add_step("alloc_at_2", OVC9, NONE, NONE, '0, NONE, NONE, 3, ~OVC9, ALL);
        add_step("credit_held_2", NONE, NONE, NONE, '0, OVC9, NONE, 3, ~OVC9, ALL);
        add_step("credit_held_3", NONE, NONE, NONE, '0, OVC9, NONE, 3, ~OVC9, ALL);
        add_step("tail_p0_final", NONE, IVC1, IVC1, GDP_P0_TO_P2, NONE, NONE, 3, ALL, ALL);
    endtask

    // advance counters and status bits by one step and then predict both outputs
    task automatic run_model(input int s);
        ovc_vec_t dec;
        ovc_vec_t rel;
        int       k;
        int       o;
        dec = tab_alloc[s];  // head flit of a new packet spends a credit
        rel = '0;
        for (int p = 0; p < NUM_PORT; p++) begin
            for (int v = 0; v < NUM_VC; v++) begin
                k = p * NUM_VC + v;
                for (int j = 0; j < NUM_DEST; j++) begin
                    for (int b = 0; b < NUM_VC; b++) begin
                        o = route_port(p, j) * NUM_VC + b;
                        if (tab_gnt_ivc[s][k] && tab_gnt_dest[s][p*NUM_DEST + j]
                            && assigned_ovc_num[k*NUM_VC + b]) begin
                            dec[o] = 1'b1;
                            rel[o] = rel[o] | tab_tail[s][k];
                        end
                    end
                end
            end
        end
        for (int n = 0; n < NUM_OVC; n++) begin
            if (tab_credit[s][n] && !dec[n]) begin
                ref_count[n]++;
            end else if (!tab_credit[s][n] && dec[n]) begin
                ref_count[n]--;
            end
            if (tab_alloc[s][n]) begin
                ref_status[n] = 1'b1;
            end else if (rel[n]) begin
                ref_status[n] = 1'b0;
            end
            model_avail[n] = !ref_status[n] && (ref_count[n] > 1);
        end
        for (int i = 0; i < NUM_OVC; i++) begin
            model_not_full[i] = 1'b1;
            for (int j = 0; j < NUM_DEST; j++) begin
                for (int b = 0; b < NUM_VC; b++) begin
                    o = route_port(i / NUM_VC, j) * NUM_VC + b;
                    if (dest_port[i*NUM_DEST + j] && assigned_ovc_num[i*NUM_VC + b]) begin
                        if (ref_count[o] == 0 || (tab_sw[s][i] && ref_count[o] <= 1)) begin
                            model_not_full[i] = 1'b0;
                        end
                    end
                end
            end
        end
    endtask

    task automatic apply_step(input int s);
        @(negedge clk);
        ovc_allocated     = tab_alloc[s];
        flit_is_tail      = tab_tail[s];
        granted_ivc       = tab_gnt_ivc[s];
        granted_dest_port = tab_gnt_dest[s];
        credit_in         = tab_credit[s];
        ivc_sw_grant      = tab_sw[s];  // level held through the idle cycles
        run_model(s);
        repeat (tab_idle[s]) begin
            @(negedge clk);
            ovc_allocated     = '0;
            flit_is_tail      = '0;
            granted_ivc       = '0;
            granted_dest_port = '0;
            credit_in         = '0;
        end
        assert (model_avail == tab_exp_avail[s])
            else stop_on_failure($sformatf("table entry %s disagrees with the model on %s",
                                           tab_name[s], "ovc_available"));
        assert (model_not_full == tab_exp_not_full[s])
            else stop_on_failure($sformatf("table entry %s disagrees with the model on %s",
                                           tab_name[s], "assigned_ovc_not_full"));
        assert (ovc_available === tab_exp_avail[s])
            else stop_on_failure($sformatf("error %s: ovc_available expected %h actual %h",
                                           tab_name[s], tab_exp_avail[s], ovc_available));
        assert (assigned_ovc_not_full === tab_exp_not_full[s])
            else stop_on_failure($sformatf(
                "error %s: assigned_ovc_not_full expected %h actual %h",
                tab_name[s], tab_exp_not_full[s], assigned_ovc_not_full));
    endtask

    initial begin
        reset             = 1'b1;
        ovc_allocated     = '0;
        flit_is_tail      = '0;
        assigned_ovc_num  = '0;
        dest_port         = '0;
        granted_dest_port = '0;
        granted_ivc       = '0;
        credit_in         = '0;
        ivc_sw_grant      = '0;
        // static vc assignment where two input vcs share ovc 9
        assigned_ovc_num[1*NUM_VC +: NUM_VC]   = 4'b0010;
        dest_port[1*NUM_DEST +: NUM_DEST]      = 4'b0010;
        assigned_ovc_num[17*NUM_VC +: NUM_VC]  = 4'b0010;
        dest_port[17*NUM_DEST +: NUM_DEST]     = 4'b0100;
        assigned_ovc_num[18*NUM_VC +: NUM_VC]  = 4'b0010;
        dest_port[18*NUM_DEST +: NUM_DEST]     = 4'b0001;
        build_table();
        for (int n = 0; n < NUM_OVC; n++) begin
            ref_count[n]  = CREDIT_INIT;
            ref_status[n] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int s = 0; s < num_filled; s++) begin
            apply_step(s);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/credit_counter_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_counter_sva (
    input wire                      clk,
    input wire                      reset,
    input wire                      ovc_allocated,
    input wire                      credit_dec,
    input wire                      ovc_release,
    input wire                      credit_in,
    input wire                      full,
    input wire credit_pkg::credit_t credit_count,
    input wire                      ovc_status
);
    import credit_pkg::*;

    // a returned credit must fit into the counter
    credit_no_overflow: assert property (@(posedge clk) disable iff (reset)
        credit_in |-> credit_count != credit_t'(CREDIT_INIT))
        else $error("credit returned to an ovc whose counter is already at its maximum");

    // flit sent to an ovc with no free buffer slot
    credit_no_underflow: assert property (@(posedge clk) disable iff (reset)
        credit_dec |-> !full)
        else $error("credit spent on an ovc that is full");

    alloc_release_apart: assert property (@(posedge clk) disable iff (reset)
        !(ovc_allocated && ovc_release))
        else $error("ovc allocated and released in the same cycle");

    release_when_held: assert property (@(posedge clk) disable iff (reset)
        ovc_release |-> ovc_status)
        else $error("ovc released while it is free");

    alloc_when_free: assert property (@(posedge clk) disable iff (reset)
        ovc_allocated |-> !ovc_status)
        else $error("ovc allocated while it is already allocated");

endmodule

bind ovc_credit_slot credit_counter_sva credit_counter_sva_inst (
    .clk           (clk),
    .reset         (reset),
    .ovc_allocated (ovc_allocated),
    .credit_dec    (credit_dec),
    .ovc_release   (ovc_release),
    .credit_in     (credit_in),
    .full          (full),
    .credit_count  (credit_count),
    .ovc_status    (ovc_status)
);

`default_nettype wire

/* logic/credit_counter_top.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_counter_top (
    input  wire                             clk,
    input  wire                             reset,
    input  wire credit_pkg::ovc_vec_t       ovc_allocated,
    input  wire credit_pkg::ovc_vec_t       flit_is_tail,
    input  wire credit_pkg::ovc_num_all_t   assigned_ovc_num,
    input  wire credit_pkg::dest_all_t      dest_port,
    input  wire credit_pkg::port_dest_all_t granted_dest_port,
    input  wire credit_pkg::ovc_vec_t       granted_ivc,
    input  wire credit_pkg::ovc_vec_t       credit_in,
    input  wire credit_pkg::ovc_vec_t       ivc_sw_grant,
    output wire credit_pkg::ovc_vec_t       ovc_available,
    output wire credit_pkg::ovc_vec_t       assigned_ovc_not_full
);
    import credit_pkg::*;

    wire ovc_vec_t credit_dec;       // per ovc, from switch grants and allocation
    wire ovc_vec_t ovc_release;      // per ovc, tail flit leaving
    wire ovc_vec_t ovc_full;
    wire ovc_vec_t ovc_nearly_full;

    grant_decoder grant_decoder_inst (
        .flit_is_tail      (flit_is_tail),
        .assigned_ovc_num  (assigned_ovc_num),
        .granted_dest_port (granted_dest_port),
        .granted_ivc       (granted_ivc),
        .ovc_allocated     (ovc_allocated),
        .credit_dec        (credit_dec),
        .ovc_release       (ovc_release)
    );

    // one counter and status bit per output vc
    for (genvar g = 0; g < NUM_OVC; g++) begin : slot_gen
        ovc_credit_slot ovc_credit_slot_inst (
            .clk           (clk),
            .reset         (reset),
            .ovc_allocated (ovc_allocated[g]),
            .credit_dec    (credit_dec[g]),
            .ovc_release   (ovc_release[g]),
            .credit_in     (credit_in[g]),
            .full          (ovc_full[g]),
            .nearly_full   (ovc_nearly_full[g]),
            .ovc_available (ovc_available[g])
        );
    end

    full_mask_gen full_mask_gen_inst (
        .clk                   (clk),
        .reset                 (reset),
        .assigned_ovc_num      (assigned_ovc_num),
        .dest_port             (dest_port),
        .ivc_sw_grant          (ivc_sw_grant),
        .ovc_full              (ovc_full),
        .ovc_nearly_full       (ovc_nearly_full),
        .credit_in             (credit_in),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

endmodule

`default_nettype wire

/* logic/full_mask_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module full_mask_gen (
    input  wire                            clk,
    input  wire                            reset,
    input  wire credit_pkg::ovc_num_all_t  assigned_ovc_num,
    input  wire credit_pkg::dest_all_t     dest_port,
    input  wire credit_pkg::ovc_vec_t      ivc_sw_grant,
    input  wire credit_pkg::ovc_vec_t      ovc_full,
    input  wire credit_pkg::ovc_vec_t      ovc_nearly_full,
    input  wire credit_pkg::ovc_vec_t      credit_in,
    output credit_pkg::ovc_vec_t           assigned_ovc_not_full
);
    import credit_pkg::*;

    ovc_vec_t full_masked;
    ovc_vec_t nearly_full_masked;
    ovc_vec_t full_sel;         // assigned ovc is full
    ovc_vec_t nearly_full_sel;  // assigned ovc nearly full and vc sending now
    ovc_vec_t full_reg;
    ovc_vec_t nearly_full_reg;

    // flag of the ovc that input vc k holds, picked through its destination
    function automatic logic pick_flag(
        input ovc_vec_t  flags,
        input int        k,
        input dest_sel_t dest,
        input vc_vec_t   ovc_num
    );
        vc_vec_t port_flags;
        port_flags = '0;
        for (int j = 0; j < NUM_DEST; j++) begin
            if (dest[j]) begin
                port_flags = port_flags
                           | flags[dest_to_port(k / NUM_VC, j)*NUM_VC +: NUM_VC];
            end
        end
        return |(port_flags & ovc_num);
    endfunction

    // a returning credit frees one slot this cycle
    assign full_masked        = ovc_full & ~credit_in;
    assign nearly_full_masked = ovc_nearly_full & ~credit_in;

    always_comb begin
        for (int k = 0; k < NUM_OVC; k++) begin
            full_sel[k] = pick_flag(full_masked, k,
                                    dest_port[k*NUM_DEST +: NUM_DEST],
                                    assigned_ovc_num[k*NUM_VC +: NUM_VC]);
            // the flit granted now takes the last slot
            nearly_full_sel[k] = ivc_sw_grant[k]
                               & pick_flag(nearly_full_masked, k,
                                           dest_port[k*NUM_DEST +: NUM_DEST],
                                           assigned_ovc_num[k*NUM_VC +: NUM_VC]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_reg        <= '0;
            nearly_full_reg <= '0;
        end else begin
            full_reg        <= full_sel;
            nearly_full_reg <= nearly_full_sel;
        end
    end

    assign assigned_ovc_not_full = ~(full_reg | nearly_full_reg);

endmodule

`default_nettype wire

/* logic/ovc_credit_slot.sv */
`timescale 1ns/1ns
`default_nettype none

module ovc_credit_slot (
    input  wire  clk,
    input  wire  reset,
    input  wire  ovc_allocated,
    input  wire  credit_dec,
    input  wire  ovc_release,
    input  wire  credit_in,
    output logic full,
    output logic nearly_full,
    output logic ovc_available
);
    import credit_pkg::*;

    credit_t credit_count;  // free slots in the downstream buffer
    credit_t count_next;
    logic    ovc_status;    // high while allocated to an input vc

    // simultaneous increment and decrement cancel out
    always_comb begin
        count_next = credit_count;
        if (credit_in && !credit_dec) begin
            count_next = credit_count + 1'b1;
        end else if (!credit_in && credit_dec) begin
            count_next = credit_count - 1'b1;
        end
    end

    // flags come from the next count so they line up with the counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_count <= credit_t'(CREDIT_INIT);
            full         <= (CREDIT_INIT == 0);
            nearly_full  <= (CREDIT_INIT <= 1);
        end else begin
            credit_count <= count_next;
            full         <= (count_next == '0);
            nearly_full  <= (count_next <= credit_t'(1));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_status <= 1'b0;
        end else if (ovc_allocated) begin
            ovc_status <= 1'b1;
        end else if (ovc_release) begin
            ovc_status <= 1'b0;
        end
    end

    // non-atomic reuse: a free ovc with room for two flits can be handed out
    assign ovc_available = ~ovc_status & ~nearly_full;

endmodule

`default_nettype wire

/* logic/grant_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module grant_decoder (
    input  wire credit_pkg::ovc_vec_t        flit_is_tail,
    input  wire credit_pkg::ovc_num_all_t    assigned_ovc_num,
    input  wire credit_pkg::port_dest_all_t  granted_dest_port,
    input  wire credit_pkg::ovc_vec_t        granted_ivc,
    input  wire credit_pkg::ovc_vec_t        ovc_allocated,
    output credit_pkg::ovc_vec_t             credit_dec,
    output credit_pkg::ovc_vec_t             ovc_release
);
    import credit_pkg::*;

    ovc_vec_t port_dec [NUM_PORT];  // decrement request of each input port
    ovc_vec_t port_rel [NUM_PORT];  // release request of each input port

    for (genvar i = 0; i < NUM_PORT; i++) begin : port_gen
        vc_vec_t   sel_ovc;   // assigned ovc of the granted vc
        logic      sel_tail;  // granted vc carries a tail flit
        dest_sel_t sel_dest;
        ovc_vec_t  dec_part;

        assign sel_dest = granted_dest_port[i*NUM_DEST +: NUM_DEST];

        // one-hot mux over the vcs of this port
        always_comb begin
            sel_ovc  = '0;
            sel_tail = 1'b0;
            for (int v = 0; v < NUM_VC; v++) begin
                if (granted_ivc[i*NUM_VC + v]) begin
                    sel_ovc  = sel_ovc | assigned_ovc_num[(i*NUM_VC + v)*NUM_VC +: NUM_VC];
                    sel_tail = sel_tail | flit_is_tail[i*NUM_VC + v];
                end
            end
        end

        // spread the local ovc number onto the granted output port
        always_comb begin
            dec_part = '0;
            for (int j = 0; j < NUM_DEST; j++) begin
                if (sel_dest[j]) begin
                    dec_part[dest_to_port(i, j)*NUM_VC +: NUM_VC] = sel_ovc;
                end
            end
        end

        assign port_dec[i] = dec_part;
        assign port_rel[i] = sel_tail ? dec_part : '0;  // only tails free the ovc
    end

    // merge all input ports; allocation spends the credit of the head flit
    always_comb begin
        credit_dec  = ovc_allocated;
        ovc_release = '0;
        for (int i = 0; i < NUM_PORT; i++) begin
            credit_dec  = credit_dec | port_dec[i];
            ovc_release = ovc_release | port_rel[i];
        end
    end

endmodule

`default_nettype wire

/* logic/credit_pkg.sv */
`default_nettype none

package credit_pkg;

    // router sizing
    localparam int NUM_VC      = 4;                  // vcs per port
    localparam int NUM_PORT    = 5;
    localparam int NUM_DEST    = NUM_PORT - 1;       // no route back to the own port
    localparam int NUM_OVC     = NUM_PORT * NUM_VC;  // same count as input vcs

    // buffer and credit sizing
    localparam int BUF_DEPTH   = 4;                  // flits per ovc buffer
    localparam int CREDIT_W    = $clog2(BUF_DEPTH);
    localparam int CREDIT_INIT = BUF_DEPTH - 1;      // reset value and max count

    typedef logic [CREDIT_W-1:0]            credit_t;
    typedef logic [NUM_VC-1:0]              vc_vec_t;
    typedef logic [NUM_DEST-1:0]            dest_sel_t;       // one-hot
    typedef logic [NUM_OVC-1:0]             ovc_vec_t;
    typedef logic [NUM_OVC*NUM_VC-1:0]      ovc_num_all_t;    // one-hot per input vc
    typedef logic [NUM_OVC*NUM_DEST-1:0]    dest_all_t;       // one-hot per input vc
    typedef logic [NUM_PORT*NUM_DEST-1:0]   port_dest_all_t;  // one-hot per input port

    // Destination index j seen from input port in_port names output port j
    // below the input port and j+1 above it, since the own port is skipped.
    function automatic int dest_to_port(input int in_port, input int dest);
        int out_port;
        if (dest < in_port) begin
            out_port = dest;
        end else begin
            out_port = dest + 1;
        end
        return out_port;
    endfunction

endpackage

`default_nettype wire
